//--- hw/net_node_pkg.sv
`default_nettype none

package net_node_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths

   localparam int LINK_W    = 64;                  // one link beat
   localparam int NODE_ID_W = 10;                  // node address

   typedef logic [NODE_ID_W-1:0] node_id_t;        // all ones in dst = broadcast
   typedef logic [9:0]           hop_step_t;       // all ones = hops used up

   ////////////////////////////////////////////////////////////////////////////
   // frame layout

   typedef struct packed {
      logic [3:0]  rsvd;                           // reserved
      logic [3:0]  op;                             // opcode
      logic [5:0]  flags;
      node_id_t    dst;                            // destination node
      node_id_t    src;                            // source node
      hop_step_t   step;                           // hop counter
      logic [19:0] tag;
   } net_hdr_t;                                    // 64 bits, one beat

   typedef struct packed {
      net_hdr_t          hdr;                      // first beat
      logic [LINK_W-1:0] data;                     // second beat
   } net_frame_t;

   // link beat, ready travels back on its own wire
   typedef struct packed {
      logic              valid;
      logic              last;                     // high on the data beat
      logic [LINK_W-1:0] data;
   } link_beat_t;

   ////////////////////////////////////////////////////////////////////////////
   // enums and commands

   typedef enum logic {
      CH_A,                                        // ring direction
      CH_B                                         // answer direction
   } chan_e;

   typedef enum logic [1:0] {
      ROUTE_DISCARD,
      ROUTE_PROCESS,
      ROUTE_FORWARD
   } route_e;

   typedef struct packed {
      chan_e      chan;                            // arrival channel
      net_frame_t frame;
   } node_cmd_t;                                   // 129 bits

   typedef enum logic [1:0] {
      ST_NOT_RDY,
      ST_IDLE,
      ST_DECODE,
      ST_SEND
   } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/rx_frame_capture.sv
`default_nettype none

module rx_frame_capture import net_node_pkg::*; (
   input  wire              user_clk,
   input  wire              user_rst,
   input  wire link_beat_t  beat_i,                // receive link
   output logic             ready_o,
   input  wire              take_i,                // controller took the frame
   output logic             frame_valid_o,
   output net_frame_t       frame_o
);

   logic              wait_hdr_q;                  // next beat is a header
   logic              held_q;                      // full frame waiting
   logic              xfer;
   net_hdr_t          hdr_q;
   logic [LINK_W-1:0] data_q;

   assign ready_o       = ~held_q;                 // no overwrite of a held frame
   assign xfer          = beat_i.valid & ready_o;
   assign frame_valid_o = held_q;
   assign frame_o       = '{hdr: hdr_q, data: data_q};

   always_ff @(posedge user_clk, posedge user_rst) begin
      if (user_rst) begin
         wait_hdr_q <= 1'b1;
         held_q     <= 1'b0;
      end else begin
         if (take_i)
            held_q <= 1'b0;                        // ready again next cycle
         if (xfer) begin
            if (wait_hdr_q) begin
               if (!beat_i.last)
                  wait_hdr_q <= 1'b0;              // lone last beat is dropped
            end else if (beat_i.last) begin
               wait_hdr_q <= 1'b1;
               held_q     <= 1'b1;                 // frame complete
            end
         end
      end
   end

   // payload
   always_ff @(posedge user_clk) begin
      if (xfer) begin
         if (wait_hdr_q && !beat_i.last)
            hdr_q <= beat_i.data;
         else if (!wait_hdr_q && beat_i.last)
            data_q <= beat_i.data;
      end
   end

   // a held frame stays intact until the controller takes it
   a_held_frame_stable : assert property (
      @(posedge user_clk) disable iff (user_rst)
      (frame_valid_o && !take_i) |=> (frame_valid_o && $stable(frame_o))
   );

endmodule

`default_nettype wire

//--- hw/hdr_route_decode.sv
`default_nettype none

module hdr_route_decode import net_node_pkg::*; (
   input  wire net_hdr_t  hdr_i,                   // header under decision
   input  wire node_id_t  node_id_i,               // own address
   output route_e         route_o,
   output net_hdr_t       fwd_hdr_o                // header for the next hop
);

   logic id_ok;                                    // node has an address
   logic exhausted;                                // no hops left
   logic to_all;
   logic to_me;
   logic from_me;                                  // came back around the ring

   assign id_ok     = |node_id_i;
   assign exhausted = id_ok & (&hdr_i.step);
   assign to_all    = &hdr_i.dst;
   assign to_me     = id_ok & (hdr_i.dst == node_id_i);
   assign from_me   = (hdr_i.src == node_id_i);

   always_comb begin
      if (exhausted)
         route_o = ROUTE_DISCARD;
      else if (to_all || to_me || from_me)
         route_o = ROUTE_PROCESS;
      else
         route_o = ROUTE_FORWARD;
   end

   // same header, one more hop, wraps to zero
   always_comb begin
      fwd_hdr_o      = hdr_i;
      fwd_hdr_o.step = hdr_i.step + 1'b1;
   end

endmodule

`default_nettype wire

//--- hw/tx_frame_sender.sv
`default_nettype none

module tx_frame_sender import net_node_pkg::*; (
   input  wire              user_clk,
   input  wire              user_rst,
   input  wire              start_i,               // load a frame
   input  wire net_frame_t  frame_i,
   input  wire chan_e       chan_i,
   input  wire              abort_i,               // drop the frame in flight
   output logic             busy_o,
   output link_beat_t       tx_a_o,
   input  wire              tx_a_ready_i,
   output link_beat_t       tx_b_o,
   input  wire              tx_b_ready_i
);

   logic       busy_q;
   logic       data_ph_q;                          // 0 header, 1 data
   chan_e      chan_q;
   net_frame_t frame_q;
   link_beat_t beat;                               // beat on the chosen link
   logic       ready_sel;
   logic       xfer;
   logic       load;

   assign load      = start_i & ~busy_q;
   assign ready_sel = (chan_q == CH_B) ? tx_b_ready_i : tx_a_ready_i;
   assign xfer      = beat.valid & ready_sel;
   assign busy_o    = busy_q;

   assign beat.valid = busy_q;
   assign beat.last  = data_ph_q;
   assign beat.data  = data_ph_q ? frame_q.data : frame_q.hdr;

   assign tx_a_o = (chan_q == CH_A) ? beat : '0;   // other link stays quiet
   assign tx_b_o = (chan_q == CH_B) ? beat : '0;

   always_ff @(posedge user_clk, posedge user_rst) begin
      if (user_rst) begin
         busy_q    <= 1'b0;
         data_ph_q <= 1'b0;
         chan_q    <= CH_A;
      end else if (abort_i) begin
         busy_q    <= 1'b0;                        // frame abandoned
         data_ph_q <= 1'b0;
      end else if (load) begin
         busy_q    <= 1'b1;
         data_ph_q <= 1'b0;
         chan_q    <= chan_i;
      end else if (xfer) begin
         if (data_ph_q) begin
            busy_q    <= 1'b0;                     // last beat gone
            data_ph_q <= 1'b0;
         end else begin
            data_ph_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge user_clk) begin
      if (load)
         frame_q <= frame_i;
   end

   // stream rule, a stalled beat holds until it transfers
   a_beat_stable : assert property (
      @(posedge user_clk) disable iff (user_rst)
      (beat.valid && !ready_sel && !abort_i) |=> $stable(beat)
   );

endmodule

`default_nettype wire

//--- hw/node_ctrl.sv
`default_nettype none

module node_ctrl import net_node_pkg::*; #(
   parameter int TIMEOUT_W = 10                    // stall limit 2**(TIMEOUT_W-1)
) (
   input  wire              user_clk,
   input  wire              user_rst,
   input  wire [1:0]        chan_up_i,             // link A and B up
   // captures
   input  wire              a_valid_i,
   input  wire net_frame_t  a_frame_i,
   output logic             a_take_o,
   input  wire              b_valid_i,
   input  wire net_frame_t  b_frame_i,
   output logic             b_take_o,
   // decoder
   output net_hdr_t         cur_hdr_o,
   input  wire route_e      route_i,
   input  wire net_hdr_t    fwd_hdr_i,
   // sender
   output logic             send_start_o,
   output net_frame_t       send_frame_o,
   output chan_e            send_chan_o,
   output logic             send_abort_o,
   input  wire              busy_i,
   // local side
   input  wire              loc_valid_i,
   input  wire net_frame_t  loc_frame_i,
   input  wire chan_e       loc_chan_i,
   output logic             loc_ready_o,
   output logic             cmd_valid_o,
   output node_cmd_t        cmd_o,
   output logic             ready_o
);

   ctrl_state_e          state_q;
   ctrl_state_e          state_d;
   logic [TIMEOUT_W-1:0] stall_cnt_q;
   logic                 time_out;
   logic                 drop;                     // fall back to not ready
   net_frame_t           cur_frame_q;              // frame under decision
   chan_e                cur_chan_q;

   assign time_out     = stall_cnt_q[TIMEOUT_W-1];
   assign drop         = time_out | ~&chan_up_i;
   assign send_abort_o = drop;
   assign ready_o      = (state_q != ST_NOT_RDY);
   assign cur_hdr_o    = cur_frame_q.hdr;
   assign cmd_o        = '{chan: cur_chan_q, frame: cur_frame_q}; // stable until next take

   ////////////////////////////////////////////////////////////////////////////
   // next state, A over B over local

   always_comb begin
      state_d      = state_q;
      a_take_o     = 1'b0;
      b_take_o     = 1'b0;
      loc_ready_o  = 1'b0;
      send_start_o = 1'b0;
      send_frame_o = cur_frame_q;
      send_chan_o  = cur_chan_q;
      case (state_q)
         ST_NOT_RDY: begin
            if (&chan_up_i)
               state_d = ST_IDLE;
         end
         ST_IDLE: begin
            loc_ready_o = ~a_valid_i & ~b_valid_i & ~busy_i;
            if (a_valid_i) begin
               a_take_o = 1'b1;
               state_d  = ST_DECODE;
            end else if (b_valid_i) begin
               b_take_o = 1'b1;
               state_d  = ST_DECODE;
            end else if (loc_valid_i && loc_ready_o) begin
               send_start_o = 1'b1;                // local frame goes out as is
               send_frame_o = loc_frame_i;
               send_chan_o  = loc_chan_i;
               state_d      = ST_SEND;
            end
         end
         ST_DECODE: begin
            if (route_i == ROUTE_FORWARD) begin
               send_start_o = 1'b1;                // back out on arrival channel
               send_frame_o = '{hdr: fwd_hdr_i, data: cur_frame_q.data};
               state_d      = ST_SEND;
            end else begin
               state_d = ST_IDLE;                  // process or discard
            end
         end
         ST_SEND: begin
            if (!busy_i)
               state_d = ST_IDLE;
         end
         default: state_d = ST_NOT_RDY;
      endcase
      if (drop) begin
         state_d      = ST_NOT_RDY;
         a_take_o     = 1'b0;
         b_take_o     = 1'b0;
         loc_ready_o  = 1'b0;
         send_start_o = 1'b0;
      end
   end

   always_ff @(posedge user_clk, posedge user_rst) begin
      if (user_rst) begin
         state_q     <= ST_NOT_RDY;
         stall_cnt_q <= '0;
         cmd_valid_o <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_DECODE || state_q == ST_SEND)
            stall_cnt_q <= stall_cnt_q + 1'b1;     // busy outside idle
         else
            stall_cnt_q <= '0;
         cmd_valid_o <= (state_q == ST_DECODE) && (route_i == ROUTE_PROCESS) && !drop;
      end
   end

   // frame latch
   always_ff @(posedge user_clk) begin
      if (a_take_o) begin
         cur_frame_q <= a_frame_i;
         cur_chan_q  <= CH_A;
      end else if (b_take_o) begin
         cur_frame_q <= b_frame_i;
         cur_chan_q  <= CH_B;
      end
   end

   // each processed frame yields exactly one command pulse
   a_cmd_single : assert property (
      @(posedge user_clk) disable iff (user_rst)
      cmd_valid_o |=> !cmd_valid_o
   );

endmodule

`default_nettype wire

//--- hw/net_node_top.sv
`default_nettype none

module net_node_top import net_node_pkg::*; #(
   parameter int TIMEOUT_W = 10
) (
   input  wire              user_clk,
   input  wire              user_rst,
   input  wire node_id_t    node_id_i,
   input  wire [1:0]        chan_up_i,
   // receive links
   input  wire link_beat_t  rx_a_i,
   output logic             rx_a_ready_o,
   input  wire link_beat_t  rx_b_i,
   output logic             rx_b_ready_o,
   // transmit links
   output link_beat_t       tx_a_o,
   input  wire              tx_a_ready_i,
   output link_beat_t       tx_b_o,
   input  wire              tx_b_ready_i,
   // local side
   input  wire              loc_valid_i,
   input  wire net_frame_t  loc_frame_i,
   input  wire chan_e       loc_chan_i,
   output logic             loc_ready_o,
   output logic             cmd_valid_o,
   output node_cmd_t        cmd_o,
   output logic             ready_o
);

   logic       a_valid, a_take;
   logic       b_valid, b_take;
   net_frame_t a_frame, b_frame;
   net_hdr_t   cur_hdr, fwd_hdr;
   route_e     route;
   logic       send_start, send_abort, send_busy;
   net_frame_t send_frame;
   chan_e      send_chan;

   rx_frame_capture i_rx_a (                       // ring direction
      .user_clk      (user_clk),
      .user_rst      (user_rst),
      .beat_i        (rx_a_i),
      .ready_o       (rx_a_ready_o),
      .take_i        (a_take),
      .frame_valid_o (a_valid),
      .frame_o       (a_frame)
   );

   rx_frame_capture i_rx_b (                       // answer direction
      .user_clk      (user_clk),
      .user_rst      (user_rst),
      .beat_i        (rx_b_i),
      .ready_o       (rx_b_ready_o),
      .take_i        (b_take),
      .frame_valid_o (b_valid),
      .frame_o       (b_frame)
   );

   hdr_route_decode i_hdr_route_decode (
      .hdr_i     (cur_hdr),
      .node_id_i (node_id_i),
      .route_o   (route),
      .fwd_hdr_o (fwd_hdr)
   );

   node_ctrl #(
      .TIMEOUT_W (TIMEOUT_W)
   ) i_node_ctrl (
      .user_clk     (user_clk),
      .user_rst     (user_rst),
      .chan_up_i    (chan_up_i),
      .a_valid_i    (a_valid),
      .a_frame_i    (a_frame),
      .a_take_o     (a_take),
      .b_valid_i    (b_valid),
      .b_frame_i    (b_frame),
      .b_take_o     (b_take),
      .cur_hdr_o    (cur_hdr),
      .route_i      (route),
      .fwd_hdr_i    (fwd_hdr),
      .send_start_o (send_start),
      .send_frame_o (send_frame),
      .send_chan_o  (send_chan),
      .send_abort_o (send_abort),
      .busy_i       (send_busy),
      .loc_valid_i  (loc_valid_i),
      .loc_frame_i  (loc_frame_i),
      .loc_chan_i   (loc_chan_i),
      .loc_ready_o  (loc_ready_o),
      .cmd_valid_o  (cmd_valid_o),
      .cmd_o        (cmd_o),
      .ready_o      (ready_o)
   );

   tx_frame_sender i_tx_frame_sender (
      .user_clk     (user_clk),
      .user_rst     (user_rst),
      .start_i      (send_start),
      .frame_i      (send_frame),
      .chan_i       (send_chan),
      .abort_i      (send_abort),
      .busy_o       (send_busy),
      .tx_a_o       (tx_a_o),
      .tx_a_ready_i (tx_a_ready_i),
      .tx_b_o       (tx_b_o),
      .tx_b_ready_i (tx_b_ready_i)
   );

endmodule

`default_nettype wire

//--- dv/tb_net_node_top.sv
`default_nettype none

module tb_net_node_top import net_node_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam node_id_t MY_ID = 10'h0a5;           // own address, nonzero
   localparam int       TMO   = 200;               // cycles per wait loop

   logic       user_clk, user_rst;
   node_id_t   node_id_i;
   logic [1:0] chan_up_i;
   link_beat_t rx_a_i, rx_b_i, tx_a_o, tx_b_o;
   logic       rx_a_ready_o, rx_b_ready_o, tx_a_ready_i, tx_b_ready_i;
   logic       loc_valid_i, loc_ready_o, cmd_valid_o, ready_o;
   net_frame_t loc_frame_i;
   chan_e      loc_chan_i;
   node_cmd_t  cmd_o;

   logic [31:0] seed, stall_seed;
   int          a_mode;                            // tx_a ready: 0 high, 1 random, 2 low
   int          errors = 0;
   int          tests  = 0;
   int          fails  = 0;
   node_cmd_t   cmd_q[$], exp_cmd[$];              // seen and predicted commands
   link_beat_t  txa_q[$], txb_q[$], exp_a[$], exp_b[$];

   net_node_top #(.TIMEOUT_W(6)) i_net_node_top (.*);

   always #5 user_clk = ~user_clk;                 // 10 ns period

   always @(negedge user_clk) begin                // tx_a back-pressure
      stall_seed   = xorshift(stall_seed);
      tx_a_ready_i = (a_mode == 0) || (a_mode == 1 && stall_seed[1:0] != 2'b00);
   end

   always @(posedge user_clk) begin                // monitor, transfers only
      if (cmd_valid_o)
         cmd_q.push_back(cmd_o);
      if (tx_a_o.valid && tx_a_ready_i)
         txa_q.push_back(tx_a_o);
      if (tx_b_o.valid && tx_b_ready_i)
         txb_q.push_back(tx_b_o);
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers and reference model

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic net_frame_t make_frame(input node_id_t dst, src, input hop_step_t step);
      net_frame_t f;
      seed   = xorshift(seed);
      f.hdr  = '{rsvd: 4'h0, op: seed[3:0], flags: seed[9:4], dst: dst, src: src,
                 step: step, tag: seed[31:12]};
      seed   = xorshift(seed);
      f.data = {seed, xorshift(seed)};             // random payload
      return f;
   endfunction

   // 0 discard, 1 process, 2 forward
   function automatic int predict(input net_hdr_t h);
      if (MY_ID != 0 && h.step == 10'h3ff)
         return 0;
      if (h.dst == 10'h3ff || (MY_ID != 0 && h.dst == MY_ID) || h.src == MY_ID)
         return 1;
      return 2;
   endfunction

   task automatic check(input string name, input logic [128:0] got, input logic [128:0] exp);
      if (got !== exp) begin
         $display("** Error: %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic push_beats(input chan_e ch, input net_frame_t f);
      link_beat_t h, d;
      h = '{valid: 1'b1, last: 1'b0, data: f.hdr};
      d = '{valid: 1'b1, last: 1'b1, data: f.data};
      if (ch == CH_A) begin
         exp_a.push_back(h);
         exp_a.push_back(d);
      end else begin
         exp_b.push_back(h);
         exp_b.push_back(d);
      end
   endtask

   task automatic expect_rx(input chan_e ch, input net_frame_t f);
      net_frame_t g;
      g          = f;
      g.hdr.step = f.hdr.step + 10'd1;             // wraps at all ones
      case (predict(f.hdr))
         1: exp_cmd.push_back('{chan: ch, frame: f});
         2: push_beats(ch, g);                     // out on arrival channel
         default: ;
      endcase
   endtask

   task automatic put_beat(input chan_e ch, input logic is_last, input logic [63:0] d);
      int   n;
      logic rdy;
      @(negedge user_clk);
      if (ch == CH_A)
         rx_a_i = '{valid: 1'b1, last: is_last, data: d};
      else
         rx_b_i = '{valid: 1'b1, last: is_last, data: d};
      n = 0;
      do begin
         @(posedge user_clk);
         rdy = (ch == CH_A) ? rx_a_ready_o : rx_b_ready_o;
         n++;
      end while (!rdy && n < TMO);
      if (!rdy) begin
         $display("receive link %s never took a beat", ch.name());
         errors++;
      end
   endtask

   task automatic send_rx(input chan_e ch, input net_frame_t f);
      put_beat(ch, 1'b0, f.hdr);
      put_beat(ch, 1'b1, f.data);
      @(negedge user_clk);
      if (ch == CH_A)
         rx_a_i = '0;
      else
         rx_b_i = '0;
   endtask

   task automatic send_loc(input chan_e ch, input net_frame_t f);
      int n;
      @(negedge user_clk);
      loc_valid_i = 1'b1;
      loc_frame_i = f;
      loc_chan_i  = ch;
      n = 0;
      do begin
         @(posedge user_clk);
         n++;
      end while (!loc_ready_o && n < TMO);         // accepted with valid and ready
      if (!loc_ready_o) begin
         $display("local frame was never accepted");
         errors++;
      end
      @(negedge user_clk);
      loc_valid_i = 1'b0;
   endtask

   task automatic wait_ready(input logic level);
      int n;
      n = 0;
      while (ready_o !== level && n < TMO) begin
         @(negedge user_clk);
         n++;
      end
      if (ready_o !== level) begin
         $display("ready_o did not reach %0b in time", level);
         errors++;
      end
   endtask

   task automatic check_outputs();
      int n;
      n = 0;
      while ((cmd_q.size() < exp_cmd.size() || txa_q.size() < exp_a.size() ||
              txb_q.size() < exp_b.size()) && n < TMO) begin
         @(negedge user_clk);
         n++;
      end
      check("cmd_valid_o pulses", cmd_q.size(), exp_cmd.size());
      check("tx_a_o beats", txa_q.size(), exp_a.size());
      check("tx_b_o beats", txb_q.size(), exp_b.size());
      foreach (exp_cmd[i])
         if (i < cmd_q.size()) check("cmd_o", cmd_q[i], exp_cmd[i]);
      foreach (exp_a[i])
         if (i < txa_q.size()) check("tx_a_o", txa_q[i], exp_a[i]);
      foreach (exp_b[i])
         if (i < txb_q.size()) check("tx_b_o", txb_q[i], exp_b[i]);
      cmd_q.delete();
      txa_q.delete();
      txb_q.delete();
      exp_cmd.delete();
      exp_a.delete();
      exp_b.delete();
   endtask

   task automatic end_test(input string name, input int e0);
      tests++;
      if (errors != e0)
         fails++;
      $display("%-10s %s", name, (errors == e0) ? "ok" : "FAILED");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests

   task automatic test_bring_up();
      int e0;
      e0 = errors;
      repeat (4) @(negedge user_clk);              // links still down
      check("ready_o", ready_o, 1'b0);
      check("loc_ready_o", loc_ready_o, 1'b0);
      check("rx_a_ready_o", rx_a_ready_o, 1'b1);
      check("rx_b_ready_o", rx_b_ready_o, 1'b1);
      chan_up_i = 2'b11;
      wait_ready(1'b1);
      end_test("bring_up", e0);
   endtask

   task automatic test_process();
      int         e0;
      net_frame_t f;
      e0 = errors;
      f = make_frame(MY_ID, 10'h111, 10'h003);     // addressed to us
      expect_rx(CH_A, f);
      send_rx(CH_A, f);
      f = make_frame(10'h3ff, 10'h111, 10'h002);   // broadcast
      expect_rx(CH_B, f);
      send_rx(CH_B, f);
      f = make_frame(10'h123, MY_ID, 10'h001);     // back from the ring
      expect_rx(CH_B, f);
      send_rx(CH_B, f);
      check_outputs();
      end_test("process", e0);
   endtask

   task automatic test_forward();
      int         e0;
      net_frame_t f;
      e0     = errors;
      a_mode = 1;
      for (int i = 0; i < 3; i++) begin
         f = make_frame(10'h123, 10'h222, (i == 2) ? 10'h3fe : 10'(i * 5));
         expect_rx(CH_A, f);
         send_rx(CH_A, f);
      end
      check_outputs();
      a_mode = 0;
      end_test("forward", e0);
   endtask

   task automatic test_discard();
      int         e0;
      net_frame_t f;
      e0 = errors;
      f = make_frame(10'h123, 10'h222, 10'h3ff);   // hops used up
      expect_rx(CH_A, f);
      send_rx(CH_A, f);
      f = make_frame(MY_ID, 10'h222, 10'h004);
      expect_rx(CH_A, f);
      send_rx(CH_A, f);
      check_outputs();
      end_test("discard", e0);
   endtask

   task automatic test_local_arb();
      int         e0;
      net_frame_t f, fa, fb;
      e0 = errors;
      f = make_frame(10'h300, MY_ID, 10'h000);
      push_beats(CH_B, f);                         // local frame unchanged
      send_loc(CH_B, f);
      check_outputs();
      fa = make_frame(MY_ID, 10'h0aa, 10'h006);
      fb = make_frame(10'h3ff, 10'h0bb, 10'h007);
      expect_rx(CH_A, fa);                         // A served first
      expect_rx(CH_B, fb);
      fork
         send_rx(CH_A, fa);
         send_rx(CH_B, fb);
      join
      check_outputs();
      end_test("local_arb", e0);
   endtask

   task automatic test_timeout();
      int         e0;
      net_frame_t f;
      e0     = errors;
      a_mode = 2;                                  // forward stalls
      f = make_frame(10'h123, 10'h222, 10'h010);
      send_rx(CH_A, f);
      wait_ready(1'b0);
      wait_ready(1'b1);
      a_mode = 0;
      f = make_frame(MY_ID, 10'h222, 10'h011);
      expect_rx(CH_A, f);
      send_rx(CH_A, f);
      check_outputs();
      end_test("timeout", e0);
   endtask

   initial begin
      user_clk     = 1'b0;
      user_rst     = 1'b1;
      node_id_i    = MY_ID;
      chan_up_i    = 2'b00;
      rx_a_i       = '0;
      rx_b_i       = '0;
      tx_a_ready_i = 1'b1;
      tx_b_ready_i = 1'b1;
      loc_valid_i  = 1'b0;
      loc_frame_i  = '0;
      loc_chan_i   = CH_A;
      a_mode       = 0;
      seed         = 32'hdad2_179c;
      stall_seed   = xorshift(32'hdad2_179c);
      repeat (8) @(posedge user_clk);
      @(negedge user_clk);
      user_rst = 1'b0;
      test_bring_up();
      test_process();
      test_forward();
      test_discard();
      test_local_arb();
      test_timeout();
      $display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
hw/net_node_pkg.sv
hw/rx_frame_capture.sv
hw/hdr_route_decode.sv
hw/tx_frame_sender.sv
hw/node_ctrl.sv
hw/net_node_top.sv
dv/tb_net_node_top.sv
